// File: hw/sa_pkg.sv
// Shared widths, matrix types, phase encoding and dimensions, imported by every attention RTL block
package sa_pkg;

    // Square matrix size and steps in one load phase
    localparam int N_DIM   = 8;
    localparam int N_STEPS = N_DIM * N_DIM;

    // Element widths
    localparam int DATA_W  = 8;
    localparam int PROJ_W  = 19;
    localparam int SCORE_W = 41;
    localparam int OUT_W   = 64;

    typedef logic signed [DATA_W-1:0]  data_t;
    typedef logic signed [PROJ_W-1:0]  proj_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic signed [OUT_W-1:0]   out_t;

    typedef logic [5:0] step_t;
    typedef logic [3:0] tcount_t;

    // One column of X, indexed by row
    typedef data_t x_col_t [N_DIM];

    // Matrices indexed [row][col]
    typedef proj_t  proj_mat_t  [N_DIM][N_DIM];
    typedef score_t score_mat_t [N_DIM][N_DIM];

    typedef enum logic [2:0] {
        PH_IDLE   = 3'd0,
        PH_LOAD_Q = 3'd1,
        PH_LOAD_K = 3'd2,
        PH_LOAD_V = 3'd3,
        PH_OUT    = 3'd4
    } phase_t;

endpackage

// File: hw/sa_ctrl.sv
// Phase sequencer for the attention core, drives phase, step, token count and the clear pulse
`timescale 1ns/10ps

module sa_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  sa_pkg::tcount_t t_in,
    output sa_pkg::phase_t  phase,
    output sa_pkg::step_t   step,
    output sa_pkg::tcount_t t_count,
    output logic            clear
);
    import sa_pkg::*;

    logic [6:0] out_len;
    logic       load_last;
    logic       out_last;

    // Output phase covers T rows of eight elements
    assign out_len   = {t_count, 3'b000};
    assign load_last = (step == step_t'(N_STEPS - 1));
    assign out_last  = ({1'b0, step} == out_len - 7'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= PH_IDLE;
            step    <= '0;
            t_count <= '0;
            clear   <= 1'b0;
        end else begin
            clear <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    step <= '0;
                    if (in_valid) begin
                        phase   <= PH_LOAD_Q;
                        t_count <= t_in;
                        clear   <= 1'b1;
                    end
                end
                PH_LOAD_Q: begin
                    step <= step + step_t'(1);
                    if (load_last) begin
                        phase <= PH_LOAD_K;
                    end
                end
                PH_LOAD_K: begin
                    step <= step + step_t'(1);
                    if (load_last) begin
                        phase <= PH_LOAD_V;
                    end
                end
                PH_LOAD_V: begin
                    // Step wraps to zero for the output phase
                    step <= step + step_t'(1);
                    if (load_last) begin
                        phase <= PH_OUT;
                    end
                end
                PH_OUT: begin
                    step <= step + step_t'(1);
                    if (out_last) begin
                        phase <= PH_IDLE;
                        step  <= '0;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                    step  <= '0;
                end
            endcase
        end
    end

endmodule

// File: hw/input_buffer.sv
// Token and query-weight store, masks padding rows and serves X columns and Wq elements per step
`timescale 1ns/10ps

module input_buffer (
    input  logic            clk,
    input  logic            rst_n,
    input  sa_pkg::phase_t  phase,
    input  sa_pkg::step_t   step,
    input  sa_pkg::tcount_t t_count,
    input  sa_pkg::data_t   in_data,
    input  sa_pkg::data_t   w_q,
    output sa_pkg::x_col_t  x_col,
    output sa_pkg::data_t   wq_elem
);
    import sa_pkg::*;

    data_t      in_data_q;
    data_t      w_q_q;
    data_t      x_mem  [N_DIM][N_DIM];
    data_t      wq_mem [N_DIM][N_DIM];
    logic [2:0] row;
    logic [2:0] col;

    assign row = step[5:3];
    assign col = step[2:0];

    // Inputs land here one cycle ahead of the matching step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_data_q <= '0;
            w_q_q     <= '0;
        end else begin
            in_data_q <= in_data;
            w_q_q     <= w_q;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_LOAD_Q) begin
            // Rows past the token count are stored as zero
            x_mem[row][col]  <= ({1'b0, row} < t_count) ? in_data_q : '0;
            wq_mem[row][col] <= w_q_q;
        end
    end

    // Column k of X where k is the step's row index
    always_comb begin
        for (int i = 0; i < N_DIM; i++) begin
            x_col[i] = x_mem[i][row];
        end
    end

    assign wq_elem = wq_mem[row][col];

endmodule

// File: hw/projection_unit.sv
// Eight-lane MAC array that accumulates one projection matrix X*W from X columns and weights
`timescale 1ns/10ps

module projection_unit #(
    parameter bit REG_WEIGHT = 1'b0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,
    input  logic              acc_en,
    input  sa_pkg::step_t     step,
    input  sa_pkg::x_col_t    x_col,
    input  sa_pkg::data_t     weight,
    output sa_pkg::proj_mat_t mat
);
    import sa_pkg::*;

    data_t      w_use;
    logic [2:0] col;

    assign col = step[2:0];

    // A live input stream is one cycle ahead of step, a stored one is not
    generate
        if (REG_WEIGHT) begin : g_wreg
            data_t w_reg;

            always_ff @(posedge clk) begin
                w_reg <= weight;
            end

            assign w_use = w_reg;
        end else begin : g_wdir
            assign w_use = weight;
        end
    endgenerate

    // Lane i adds X[i][k] * W[k][j] into element (i, j)
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mat <= '{default: '0};
        end else if (clear) begin
            mat <= '{default: '0};
        end else if (acc_en) begin
            for (int i = 0; i < N_DIM; i++) begin
                mat[i][col] <= mat[i][col] + proj_t'(x_col[i]) * proj_t'(w_use);
            end
        end
    end

endmodule

// File: hw/qk_score_unit.sv
// Builds Q and K, then fills the rectified and scaled score matrix one element per cycle
`timescale 1ns/10ps

module qk_score_unit #(
    parameter int SCORE_DIV = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  sa_pkg::phase_t     phase,
    input  sa_pkg::step_t      step,
    input  sa_pkg::x_col_t     x_col,
    input  sa_pkg::data_t      wq_elem,
    input  sa_pkg::data_t      w_k,
    output sa_pkg::score_mat_t scores
);
    import sa_pkg::*;

    proj_mat_t  q_mat;
    proj_mat_t  k_mat;
    logic       qk_en;
    logic [2:0] row;
    logic [2:0] col;
    score_t     prod [N_DIM];
    score_t     sum4 [N_DIM/2];
    score_t     sum2 [N_DIM/4];
    score_t     dot;
    score_t     score_val;

    assign qk_en = (phase == PH_LOAD_K);
    assign row   = step[5:3];
    assign col   = step[2:0];

    // Q from the stored Wq
    projection_unit #(
        .REG_WEIGHT(1'b0)
    ) i_q_proj (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .acc_en (qk_en),
        .step   (step),
        .x_col  (x_col),
        .weight (wq_elem),
        .mat    (q_mat)
    );

    // K straight from the input stream
    projection_unit #(
        .REG_WEIGHT(1'b1)
    ) i_k_proj (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .acc_en (qk_en),
        .step   (step),
        .x_col  (x_col),
        .weight (w_k),
        .mat    (k_mat)
    );

    // Q row i dot K row j through a three-level adder tree
    always_comb begin
        for (int m = 0; m < N_DIM; m++) begin
            prod[m] = score_t'(q_mat[row][m]) * score_t'(k_mat[col][m]);
        end
        for (int m = 0; m < N_DIM/2; m++) begin
            sum4[m] = prod[2*m] + prod[2*m+1];
        end
        for (int m = 0; m < N_DIM/4; m++) begin
            sum2[m] = sum4[2*m] + sum4[2*m+1];
        end
        dot = sum2[0] + sum2[1];
    end

    // ReLU then scale, dividend is never negative here
    assign score_val = dot[SCORE_W-1] ? '0 : dot / score_t'(SCORE_DIV);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scores <= '{default: '0};
        end else if (clear) begin
            scores <= '{default: '0};
        end else if (phase == PH_LOAD_V) begin
            scores[row][col] <= score_val;
        end
    end

endmodule

// File: hw/attention_output.sv
// Output stage, streams O = S*V row-major with one registered element and out_valid per cycle
`timescale 1ns/10ps

module attention_output (
    input  logic               clk,
    input  logic               rst_n,
    input  sa_pkg::phase_t     phase,
    input  sa_pkg::step_t      step,
    input  sa_pkg::score_mat_t scores,
    input  sa_pkg::proj_mat_t  v_mat,
    output logic               out_valid,
    output sa_pkg::out_t       out_data
);
    import sa_pkg::*;

    logic [2:0] row;
    logic [2:0] col;
    out_t       prod [N_DIM];
    out_t       sum4 [N_DIM/2];
    out_t       sum2 [N_DIM/4];
    out_t       dot;

    assign row = step[5:3];
    assign col = step[2:0];

    // Score row i against V column j
    always_comb begin
        for (int m = 0; m < N_DIM; m++) begin
            prod[m] = out_t'(scores[row][m]) * out_t'(v_mat[m][col]);
        end
        for (int m = 0; m < N_DIM/2; m++) begin
            sum4[m] = prod[2*m] + prod[2*m+1];
        end
        for (int m = 0; m < N_DIM/4; m++) begin
            sum2[m] = sum4[2*m] + sum4[2*m+1];
        end
        dot = sum2[0] + sum2[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (phase == PH_OUT) begin
            out_valid <= 1'b1;
            out_data  <= dot;
        end else begin
            // Data bus idles at zero
            out_valid <= 1'b0;
            out_data  <= '0;
        end
    end

endmodule

// File: hw/sa_top.sv
// Top level of the single-head self-attention core, instantiate this with the plain-level stream ports
`timescale 1ns/10ps

module sa_top #(
    parameter int SCORE_DIV = 3
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  sa_pkg::tcount_t t,
    input  sa_pkg::data_t   in_data,
    input  sa_pkg::data_t   w_q,
    input  sa_pkg::data_t   w_k,
    input  sa_pkg::data_t   w_v,
    output logic            out_valid,
    output sa_pkg::out_t    out_data
);
    import sa_pkg::*;

    phase_t     phase;
    step_t      step;
    tcount_t    t_count;
    logic       clear;
    x_col_t     x_col;
    data_t      wq_elem;
    score_mat_t scores;
    proj_mat_t  v_mat;

    sa_ctrl i_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_valid(in_valid),
        .t_in    (t),
        .phase   (phase),
        .step    (step),
        .t_count (t_count),
        .clear   (clear)
    );

    input_buffer i_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .phase   (phase),
        .step    (step),
        .t_count (t_count),
        .in_data (in_data),
        .w_q     (w_q),
        .x_col   (x_col),
        .wq_elem (wq_elem)
    );

    qk_score_unit #(
        .SCORE_DIV(SCORE_DIV)
    ) i_qk (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .phase   (phase),
        .step    (step),
        .x_col   (x_col),
        .wq_elem (wq_elem),
        .w_k     (w_k),
        .scores  (scores)
    );

    // V builds alongside the score pass
    projection_unit #(
        .REG_WEIGHT(1'b1)
    ) i_v_proj (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .acc_en (phase == PH_LOAD_V),
        .step   (step),
        .x_col  (x_col),
        .weight (w_v),
        .mat    (v_mat)
    );

    attention_output i_out (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase    (phase),
        .step     (step),
        .scores   (scores),
        .v_mat    (v_mat),
        .out_valid(out_valid),
        .out_data (out_data)
    );

endmodule

// File: test/sa_asserts.sv
// Output protocol checks for sa_top, attached to every sa_top instance through bind
`timescale 1ns/10ps

module sa_asserts (
    input logic         clk,
    input logic         rst_n,
    input logic         in_valid,
    input logic         out_valid,
    input sa_pkg::out_t out_data
);
    // Consecutive cycles with out_valid high
    logic [7:0] high_run;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            high_run <= '0;
        end else if (!out_valid) begin
            high_run <= '0;
        end else if (high_run != 8'hff) begin
            high_run <= high_run + 8'd1;
        end
    end

    idle_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_data == '0))
        else $error("out_data is nonzero while out_valid is low");

    no_rise_during_input: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> !in_valid)
        else $error("out_valid rose while in_valid was high");

    burst_length: assert property (@(posedge clk) disable iff (!rst_n)
        high_run <= 8'd64)
        else $error("out_valid stayed high for more than 64 cycles");

endmodule

bind sa_top sa_asserts i_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .out_valid(out_valid),
    .out_data (out_data)
);

// File: test/sa_tb.sv
// Directed testbench for sa_top, streams X and weight matrices and checks O = S*V against a model
`timescale 1ns/10ps

module sa_tb;
    import sa_pkg::*;

    localparam int SCORE_DIV  = 3;
    // One run is three load phases, a full output phase and a few cycles of slack
    localparam int RUN_CYCLES = 3 * N_STEPS + N_STEPS + 14;
    localparam int MAX_CYCLES = 5 * RUN_CYCLES + 650;
    localparam int WAIT_LIMIT = 16;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    in_valid;
    tcount_t t;
    data_t   in_data;
    data_t   w_q;
    data_t   w_k;
    data_t   w_v;
    logic    out_valid;
    out_t    out_data;

    data_t   x_in  [N_DIM][N_DIM];
    data_t   wq_in [N_DIM][N_DIM];
    data_t   wk_in [N_DIM][N_DIM];
    data_t   wv_in [N_DIM][N_DIM];
    longint  exp_o [N_DIM][N_DIM];
    out_t    got   [N_STEPS];
    int      cycle_count = 0;

    sa_top #(
        .SCORE_DIV(SCORE_DIV)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .t        (t),
        .in_data  (in_data),
        .w_q      (w_q),
        .w_k      (w_k),
        .w_v      (w_v),
        .out_valid(out_valid),
        .out_data (out_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run("simulation ran past the cycle limit without finishing");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error: %s got 0x%h expected 0x%h", name, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    // Reference O = ReLU(Q*K^T)/div * V with padding rows of X forced to zero
    function automatic void compute_expected(input int t_tok);
        longint q [N_DIM][N_DIM];
        longint k [N_DIM][N_DIM];
        longint v [N_DIM][N_DIM];
        longint s [N_DIM][N_DIM];
        longint xv;
        longint acc;
        for (int i = 0; i < N_DIM; i++) begin
            for (int j = 0; j < N_DIM; j++) begin
                q[i][j] = 0;
                k[i][j] = 0;
                v[i][j] = 0;
                for (int m = 0; m < N_DIM; m++) begin
                    if (i < t_tok) begin
                        xv = longint'(x_in[i][m]);
                    end else begin
                        xv = 0;
                    end
                    q[i][j] += xv * longint'(wq_in[m][j]);
                    k[i][j] += xv * longint'(wk_in[m][j]);
                    v[i][j] += xv * longint'(wv_in[m][j]);
                end
            end
        end
        for (int i = 0; i < N_DIM; i++) begin
            for (int j = 0; j < N_DIM; j++) begin
                acc = 0;
                for (int m = 0; m < N_DIM; m++) begin
                    acc += q[i][m] * k[j][m];
                end
                s[i][j] = (acc > 0) ? acc / longint'(SCORE_DIV) : 0;
            end
        end
        for (int i = 0; i < N_DIM; i++) begin
            for (int j = 0; j < N_DIM; j++) begin
                acc = 0;
                for (int m = 0; m < N_DIM; m++) begin
                    acc += s[i][m] * v[m][j];
                end
                exp_o[i][j] = acc;
            end
        end
    endfunction

    task automatic fill_random();
        for (int i = 0; i < N_DIM; i++) begin
            for (int j = 0; j < N_DIM; j++) begin
                x_in[i][j]  = data_t'($urandom);
                wq_in[i][j] = data_t'($urandom);
                wk_in[i][j] = data_t'($urandom);
                wv_in[i][j] = data_t'($urandom);
            end
        end
    endtask

    // 192 valid cycles, inputs outside their phase carry noise
    task automatic stream_inputs(input int t_tok);
        int k;
        int j;
        for (int s = 0; s < 3 * N_STEPS; s++) begin
            k = (s % N_STEPS) / N_DIM;
            j = s % N_DIM;
            @(posedge clk);
            in_valid <= 1'b1;
            t        <= (s == 0) ? tcount_t'(t_tok) : tcount_t'($urandom);
            in_data  <= (s < N_STEPS) ? x_in[k][j] : data_t'($urandom);
            w_q      <= (s < N_STEPS) ? wq_in[k][j] : data_t'($urandom);
            w_k      <= (s >= N_STEPS && s < 2 * N_STEPS) ? wk_in[k][j] : data_t'($urandom);
            w_v      <= (s >= 2 * N_STEPS) ? wv_in[k][j] : data_t'($urandom);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Expects exactly 8*T consecutive valid cycles, then out_valid low
    task automatic collect_outputs(input int t_tok);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!out_valid) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("out_valid did not rise after the input stream");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        for (int n = 0; n < t_tok * N_DIM; n++) begin
            check_value("out_valid", 64'(out_valid), 64'd1);
            got[n] = out_data;
            @(negedge clk);
        end
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("out_data", out_data, 64'd0);
    endtask

    task automatic compare_with_model(input int t_tok);
        for (int n = 0; n < t_tok * N_DIM; n++) begin
            check_value($sformatf("out_data[%0d][%0d]", n / N_DIM, n % N_DIM),
                        got[n], exp_o[n / N_DIM][n % N_DIM]);
        end
    endtask

    task automatic run_against_model(input int t_tok);
        compute_expected(t_tok);
        stream_inputs(t_tok);
        collect_outputs(t_tok);
        compare_with_model(t_tok);
    endtask

    task automatic test_reset_state();
        repeat (3) begin
            @(negedge clk);
            check_value("out_valid", 64'(out_valid), 64'd0);
            check_value("out_data", out_data, 64'd0);
        end
    endtask

    task automatic test_full_random();
        fill_random();
        run_against_model(8);
    endtask

    // Garbage on rows 1 to 7 must not leak into the result
    task automatic test_single_token();
        fill_random();
        for (int i = 1; i < N_DIM; i++) begin
            for (int j = 0; j < N_DIM; j++) begin
                x_in[i][j] = data_t'($urandom_range(127, 1));
            end
        end
        run_against_model(1);
    endtask

    // Positive Q against negative K, every score clamps to zero
    task automatic test_relu_clamp();
        fill_random();
        for (int i = 0; i < N_DIM; i++) begin
            for (int j = 0; j < N_DIM; j++) begin
                if (i < 4) begin
                    x_in[i][j] = data_t'($urandom_range(20, 1));
                end
                wq_in[i][j] = data_t'($urandom_range(20, 1));
                wk_in[i][j] = data_t'(-int'($urandom_range(20, 1)));
            end
        end
        stream_inputs(4);
        collect_outputs(4);
        for (int n = 0; n < 4 * N_DIM; n++) begin
            check_value($sformatf("out_data[%0d][%0d]", n / N_DIM, n % N_DIM),
                        got[n], 64'd0);
        end
    endtask

    task automatic test_back_to_back();
        fill_random();
        run_against_model(5);
        fill_random();
        run_against_model(8);
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        t        = '0;
        in_data  = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
        void'($urandom(46));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_full_random();
        test_single_token();
        test_relu_clamp();
        test_back_to_back();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: vlog.f
hw/sa_pkg.sv
hw/sa_ctrl.sv
hw/input_buffer.sv
hw/projection_unit.sv
hw/qk_score_unit.sv
hw/attention_output.sv
hw/sa_top.sv
test/sa_asserts.sv
test/sa_tb.sv

// File: Makefile
# Verilator build and run for the self-attention testbench
VERILATOR ?= verilator
TOP       ?= sa_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
